//--- conv_line_buffer.f
+incdir+rtl
rtl/lbuf_pkg.sv
rtl/line_writer.sv
rtl/line_bank_sram.sv
rtl/window_reader.sv
rtl/window_out.sv
rtl/conv_line_buffer.sv
test/tb_clk_gen.sv
test/tb_conv_line_buffer.sv

//--- Bender.yml
package:
  name: conv_line_buffer

sources:
  # RTL in compile order
  - include_dirs:
      - rtl
    files:
      - rtl/lbuf_pkg.sv
      - rtl/line_writer.sv
      - rtl/line_bank_sram.sv
      - rtl/window_reader.sv
      - rtl/window_out.sv
      - rtl/conv_line_buffer.sv

  # testbench
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clk_gen.sv
      - test/tb_conv_line_buffer.sv

//--- test/tb_conv_line_buffer.sv
/*
 * Testbench for the 3x3 window generator.
 * Streams random pictures in, checks each window against a reference
 * image and checks write flow control under back-pressure.
 */

`include "lbuf_defs.svh"

module tb_conv_line_buffer
    import lbuf_pkg::*;
();

    localparam int IMG_MAX  = 1024;
    localparam int WAIT_MAX = 5000;     // cycles per wait loop
    localparam int IDLE_RUN = 32;
    localparam int NWIN     = `LB_WIN * `LB_WIN;

    logic                SYS_CLK;
    logic                SYS_NRST;
    logic                sop_i;
    logic [`LB_DIMW-1:0] pic_w_i;
    logic [`LB_DIMW-1:0] pic_h_i;
    pixel_t              pix_i;
    logic                pix_vld_i;
    logic                wready_o;
    window_t             opu_win_o;
    logic                opu_vld_o;
    logic                opu_rdy_i;

    pixel_t      img [IMG_MAX];     // reference image, raster order
    logic [31:0] rng;
    int          cur_w_q;
    int          cur_h_q;
    int          exp_r_q;           // top-left of the next window
    int          exp_c_q;
    int          win_cnt_q;
    int          acc_cnt_q;         // pixels accepted this picture
    int          exp_total;
    logic        sop_seen_q;
    logic        stall_q;
    logic        take;
    window_t     exp_win;

    tb_clk_gen u_clk_gen (
        .clk_o  (SYS_CLK),
        .nrst_o (SYS_NRST)
    );

    conv_line_buffer DUT (
        .SYS_CLK   (SYS_CLK),
        .SYS_NRST  (SYS_NRST),
        .sop_i     (sop_i),
        .pic_w_i   (pic_w_i),
        .pic_h_i   (pic_h_i),
        .pix_i     (pix_i),
        .pix_vld_i (pix_vld_i),
        .wready_o  (wready_o),
        .opu_win_o (opu_win_o),
        .opu_vld_o (opu_vld_o),
        .opu_rdy_i (opu_rdy_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "testbench stopped at the first error");
    endtask

    // ========================================================================
    // reference model

    assign take      = opu_vld_o && opu_rdy_i;
    assign exp_total = (cur_w_q >= `LB_WIN && cur_h_q >= `LB_WIN)
                     ? (cur_w_q - (`LB_WIN - 1)) * (cur_h_q - (`LB_WIN - 1)) : 0;

    always_comb begin
        for (int k = 0; k < NWIN; k++) begin
            exp_win[k] = img[(exp_r_q + k / `LB_WIN) * cur_w_q + exp_c_q + k % `LB_WIN];
        end
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            cur_w_q    <= 0;
            cur_h_q    <= 0;
            exp_r_q    <= 0;
            exp_c_q    <= 0;
            win_cnt_q  <= 0;
            acc_cnt_q  <= 0;
            sop_seen_q <= 1'b0;
        end else if (sop_i) begin
            cur_w_q    <= int'(pic_w_i);
            cur_h_q    <= int'(pic_h_i);
            exp_r_q    <= 0;
            exp_c_q    <= 0;
            win_cnt_q  <= 0;
            acc_cnt_q  <= 0;
            sop_seen_q <= 1'b1;
        end else begin
            if (pix_vld_i && wready_o) begin
                acc_cnt_q <= acc_cnt_q + 1;
            end
            if (take) begin
                win_cnt_q <= win_cnt_q + 1;
                if (exp_c_q == cur_w_q - `LB_WIN) begin     // raster wrap
                    exp_c_q <= 0;
                    exp_r_q <= exp_r_q + 1;
                end else begin
                    exp_c_q <= exp_c_q + 1;
                end
            end
        end
    end

    // ========================================================================
    // checks

    assert property (@(posedge SYS_CLK) !SYS_NRST |-> (!wready_o && !opu_vld_o))
        else stop_on_error($sformatf("ERR t=%0t wready_o,opu_vld_o exp=0,0 got=%b,%b",
                                     $time, $sampled(wready_o), $sampled(opu_vld_o)));

    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST) !sop_seen_q |-> !wready_o)
        else stop_on_error($sformatf("ERR t=%0t wready_o exp=0 got=%b",
                                     $time, $sampled(wready_o)));

    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST) take |-> opu_win_o == exp_win)
        else stop_on_error($sformatf("ERR t=%0t opu_win_o exp=%h got=%h",
                                     $time, $sampled(exp_win), $sampled(opu_win_o)));

    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST) take |-> win_cnt_q < exp_total)
        else stop_on_error($sformatf("more windows than the %0d of a %0dx%0d picture",
                                     $sampled(exp_total), $sampled(cur_w_q),
                                     $sampled(cur_h_q)));

    // nothing more after the last window of a picture
    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
                     (win_cnt_q == exp_total) |-> !opu_vld_o)
        else stop_on_error($sformatf("ERR t=%0t opu_vld_o exp=0 got=%b",
                                     $time, $sampled(opu_vld_o)));

    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
                     (opu_vld_o && !opu_rdy_i) |=> opu_vld_o)
        else stop_on_error("opu_vld_o dropped before the window was taken");

    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
                     (opu_vld_o && !opu_rdy_i) |=> $stable(opu_win_o))
        else stop_on_error("opu_win_o changed while the window was stalled");

    assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
                     stall_q |-> acc_cnt_q <= 3 * cur_w_q)
        else stop_on_error($sformatf("ERR t=%0t acc_cnt_q exp<=%0d got=%0d",
                                     $time, 3 * $sampled(cur_w_q), $sampled(acc_cnt_q)));

    // ========================================================================
    // stimulus

    task automatic fill_image(input int w, input int h);
        for (int n = 0; n < w * h; n++) begin
            rng    = xorshift32(rng);
            img[n] = rng;
        end
    endtask

    task automatic start_picture(input int w, input int h);
        @(posedge SYS_CLK);
        sop_i   <= 1'b1;
        pic_w_i <= `LB_DIMW'(w);
        pic_h_i <= `LB_DIMW'(h);
        @(posedge SYS_CLK);
        sop_i   <= 1'b0;
        @(posedge SYS_CLK);     // model has latched the new size
    endtask

    task automatic feed_picture(input int w, input int h);
        int t;
        for (int n = 0; n < w * h; n++) begin
            pix_i     <= img[n];
            pix_vld_i <= 1'b1;
            t = 0;
            do begin
                @(posedge SYS_CLK);
                t++;
                if (t > WAIT_MAX) begin
                    stop_on_error($sformatf("timeout: pixel %0d was never accepted", n));
                end
            end while (!wready_o);
        end
        pix_vld_i <= 1'b0;
    endtask

    task automatic drain_windows();
        int t;
        t = 0;
        while (win_cnt_q != exp_total) begin
            @(posedge SYS_CLK);
            rng = xorshift32(rng);
            opu_rdy_i <= (rng[1:0] != 2'b00);   // ready about 3 cycles in 4
            t++;
            if (t > WAIT_MAX) begin
                stop_on_error($sformatf("timeout: only %0d of %0d windows arrived",
                                        win_cnt_q, exp_total));
            end
        end
        opu_rdy_i <= 1'b0;
    endtask

    task automatic wait_wready_idle();
        int t;
        int run;
        t   = 0;
        run = 0;
        while (run < IDLE_RUN) begin
            @(posedge SYS_CLK);
            run = wready_o ? 0 : run + 1;
            t++;
            if (t > WAIT_MAX) begin
                stop_on_error("timeout: wready_o never settled low under back-pressure");
            end
        end
    endtask

    initial begin
        int t;
        sop_i     <= 1'b0;
        pic_w_i   <= '0;
        pic_h_i   <= '0;
        pix_i     <= '0;
        pix_vld_i <= 1'b0;
        opu_rdy_i <= 1'b0;
        stall_q   <= 1'b1;
        rng     = 32'd93;

        t = 0;
        while (!SYS_NRST) begin
            @(posedge SYS_CLK);
            t++;
            if (t > WAIT_MAX) begin
                stop_on_error("timeout: reset was never released");
            end
        end

        // first picture starts with the compute unit stalled
        fill_image(7, 6);
        start_picture(7, 6);
        fork
            feed_picture(7, 6);
            begin
                wait_wready_idle();
                assert (acc_cnt_q == 3 * 7)
                    else stop_on_error($sformatf("ERR t=%0t acc_cnt_q exp=%0d got=%0d",
                                                 $time, 3 * 7, acc_cnt_q));
                stall_q <= 1'b0;
                drain_windows();
            end
        join

        // second picture, new size, random ready from the start
        fill_image(12, 5);
        start_picture(12, 5);
        fork
            feed_picture(12, 5);
            drain_windows();
        join
        repeat (IDLE_RUN) @(posedge SYS_CLK);

        $display("** PASS **");
        $finish;
    end

endmodule

//--- test/tb_clk_gen.sv
/*
 * Testbench clock and reset.
 * 20 time unit clock period, reset held low for the first 16 cycles.
 */

module tb_clk_gen (
    output logic clk_o,
    output logic nrst_o
);

    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 16;

    initial begin
        clk_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

    initial begin
        nrst_o <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        nrst_o <= 1'b1;     // released on a rising edge
    end

endmodule

//--- rtl/conv_line_buffer.sv
/*
 * Convolution line buffer top.
 * Raster pixels in, 3x3 windows out to the compute unit.
 */

`include "lbuf_defs.svh"

module conv_line_buffer
    import lbuf_pkg::*;
(
    input  logic                SYS_CLK,
    input  logic                SYS_NRST,
    input  logic                sop_i,
    input  logic [`LB_DIMW-1:0] pic_w_i,
    input  logic [`LB_DIMW-1:0] pic_h_i,
    input  pixel_t              pix_i,
    input  logic                pix_vld_i,
    output logic                wready_o,
    output window_t             opu_win_o,
    output logic                opu_vld_o,
    input  logic                opu_rdy_i
);

    wr_req_t    wr_req;
    rd_req_t    rd_req;
    pic_cfg_t   cfg;
    bank_col_t  rd_col;
    window_t    win;
    logic [1:0] fill_cnt;
    logic [1:0] row_base;
    logic       row_retire;
    logic       win_push;
    logic       win_room;

    // ========================================================================
    // input side

    line_writer u_line_writer (
        .SYS_CLK      (SYS_CLK),
        .SYS_NRST     (SYS_NRST),
        .sop_i        (sop_i),
        .pic_w_i      (pic_w_i),
        .pic_h_i      (pic_h_i),
        .pix_i        (pix_i),
        .pix_vld_i    (pix_vld_i),
        .row_retire_i (row_retire),
        .wready_o     (wready_o),
        .wr_req_o     (wr_req),
        .cfg_o        (cfg),
        .fill_cnt_o   (fill_cnt),
        .row_base_o   (row_base)
    );

    // ========================================================================
    // banks and window assembly

    line_bank_sram u_line_bank_sram (
        .SYS_CLK  (SYS_CLK),
        .wr_req_i (wr_req),
        .rd_req_i (rd_req),
        .rd_col_o (rd_col)
    );

    window_reader u_window_reader (
        .SYS_CLK      (SYS_CLK),
        .SYS_NRST     (SYS_NRST),
        .sop_i        (sop_i),
        .cfg_i        (cfg),
        .fill_cnt_i   (fill_cnt),
        .row_base_i   (row_base),
        .rd_col_i     (rd_col),
        .win_room_i   (win_room),
        .rd_req_o     (rd_req),
        .row_retire_o (row_retire),
        .win_push_o   (win_push),
        .win_o        (win)
    );

    // ========================================================================
    // output side

    window_out u_window_out (
        .SYS_CLK    (SYS_CLK),
        .SYS_NRST   (SYS_NRST),
        .win_push_i (win_push),
        .win_i      (win),
        .opu_rdy_i  (opu_rdy_i),
        .win_room_o (win_room),
        .opu_vld_o  (opu_vld_o),
        .opu_win_o  (opu_win_o)
    );

endmodule

//--- rtl/window_out.sv
/*
 * Window output holder.
 * Two-entry window queue in front of the compute unit, head entry
 * presented with a valid/ready pair.
 */

module window_out
    import lbuf_pkg::*;
(
    input  logic    SYS_CLK,
    input  logic    SYS_NRST,
    input  logic    win_push_i,
    input  window_t win_i,
    input  logic    opu_rdy_i,
    output logic    win_room_o,
    output logic    opu_vld_o,
    output window_t opu_win_o
);

    // two covers the windows still in flight behind a read
    localparam int DEPTH = 2;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    window_t         win_q [DEPTH];
    logic [PW-1:0]   wr_ptr_q;
    logic [PW-1:0]   rd_ptr_q;
    logic [CW-1:0]   cnt_q;
    logic [CW-1:0]   cnt_d;
    logic            room_q;
    logic            pop;

    // ========================================================================
    // queue control

    assign pop = opu_vld_o && opu_rdy_i;

    always_comb begin
        cnt_d = cnt_q;
        if (win_push_i && !pop) begin
            cnt_d = cnt_q + 1'b1;
        end else if (pop && !win_push_i) begin
            cnt_d = cnt_q - 1'b1;
        end
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            room_q   <= 1'b1;
        end else begin
            cnt_q  <= cnt_d;
            room_q <= (cnt_d == '0);        // empty only
            if (win_push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge SYS_CLK) begin
        if (win_push_i) begin
            win_q[wr_ptr_q] <= win_i;
        end
    end

    assign win_room_o = room_q;
    assign opu_vld_o  = (cnt_q != '0);
    assign opu_win_o  = win_q[rd_ptr_q];    // held until popped

endmodule

//--- rtl/window_reader.sv
/*
 * Window reader.
 * Scans three buffered rows column by column, rotates the bank outputs
 * into top/middle/bottom order and assembles one 3x3 window per column.
 */

`include "lbuf_defs.svh"

module window_reader
    import lbuf_pkg::*;
(
    input  logic       SYS_CLK,
    input  logic       SYS_NRST,
    input  logic       sop_i,
    input  pic_cfg_t   cfg_i,
    input  logic [1:0] fill_cnt_i,
    input  logic [1:0] row_base_i,
    input  bank_col_t  rd_col_i,
    input  logic       win_room_i,
    output rd_req_t    rd_req_o,
    output logic       row_retire_o,
    output logic       win_push_o,
    output window_t    win_o
);

    rd_state_e           state_q;
    rd_state_e           state_d;
    logic [`LB_AW-1:0]   col_q;
    logic [`LB_AW-1:0]   last_col;
    logic [`LB_DIMW-1:0] top_q;     // current top row
    logic [`LB_DIMW-1:0] last_top;
    logic                issue;
    logic                busy;
    logic                rd_vld_q;  // bank data valid this cycle
    logic                rd_last_q;
    logic                rd_ge2_q;
    logic                retire_q;
    pixel_t [`LB_WIN-1:0] col_cur;
    pixel_t [`LB_WIN-1:0] col_m1_q;
    pixel_t [`LB_WIN-1:0] col_m2_q;

    // bank holding window row k
    function automatic logic [1:0] bank_of(input logic [1:0] base, input int unsigned k);
        logic [2:0] sum;
        sum = {1'b0, base} + 3'(k);
        return (sum >= 3'(`LB_BANKS)) ? 2'(sum - 3'(`LB_BANKS)) : sum[1:0];
    endfunction

    assign last_col = `LB_AW'(cfg_i.w - 1'b1);
    assign last_top = `LB_DIMW'(cfg_i.h - `LB_WIN);
    assign issue    = (state_q == RD_SCAN) && win_room_i;
    // fill count is stale until the retire has reached the writer
    assign busy     = rd_vld_q || retire_q;

    // ========================================================================
    // FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_WAIT_ROWS: begin
                if ((fill_cnt_i == 2'(`LB_BANKS)) && !busy) begin
                    state_d = RD_SCAN;
                end
            end
            RD_SCAN: begin
                if (issue && (col_q == last_col)) begin
                    state_d = (top_q == last_top) ? RD_DONE : RD_WAIT_ROWS;
                end
            end
            default: state_d = state_q;     // idle and done wait for sop
        endcase
        if (sop_i) begin
            state_d = RD_WAIT_ROWS;
        end
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            state_q   <= RD_IDLE;
            col_q     <= '0;
            top_q     <= '0;
            rd_vld_q  <= 1'b0;
            rd_last_q <= 1'b0;
            rd_ge2_q  <= 1'b0;
            retire_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_vld_q  <= issue && !sop_i;
            rd_last_q <= issue && (col_q == last_col);
            rd_ge2_q  <= issue && (col_q >= `LB_AW'(2));
            retire_q  <= rd_vld_q && rd_last_q && !sop_i;
            if (sop_i) begin
                col_q <= '0;
                top_q <= '0;
            end else if (issue) begin
                if (col_q == last_col) begin
                    col_q <= '0;
                    top_q <= top_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rd_req_o.en   = issue;
        rd_req_o.addr = col_q;
    end

    // ========================================================================
    // window assembly

    always_comb begin
        for (int k = 0; k < `LB_WIN; k++) begin
            col_cur[k] = rd_col_i[bank_of(row_base_i, k)];
        end
    end

    always_ff @(posedge SYS_CLK) begin
        if (rd_vld_q) begin
            col_m2_q <= col_m1_q;
            col_m1_q <= col_cur;
        end
    end

    always_comb begin
        for (int r = 0; r < `LB_WIN; r++) begin
            win_o[r*`LB_WIN]     = col_m2_q[r];   // left
            win_o[r*`LB_WIN + 1] = col_m1_q[r];
            win_o[r*`LB_WIN + 2] = col_cur[r];    // right, straight from the banks
        end
    end

    assign win_push_o   = rd_vld_q && rd_ge2_q;
    assign row_retire_o = retire_q;

endmodule

//--- rtl/line_bank_sram.sv
/*
 * Line bank memories.
 * Three one-row SRAMs, one write port each and a shared read address
 * with registered data.
 */

`include "lbuf_defs.svh"

module line_bank_sram
    import lbuf_pkg::*;
(
    input  logic      SYS_CLK,
    input  wr_req_t   wr_req_i,
    input  rd_req_t   rd_req_i,
    output bank_col_t rd_col_o
);

    localparam int DEPTH = 2 ** `LB_AW;

    // ========================================================================
    // one row per bank

    for (genvar b = 0; b < `LB_BANKS; b++) begin : g_bank
        pixel_t mem [DEPTH];
        pixel_t rd_q;

        always_ff @(posedge SYS_CLK) begin
            if (wr_req_i.en && (wr_req_i.bank == 2'(b))) begin
                mem[wr_req_i.addr] <= wr_req_i.data;
            end
        end

        // all banks read the same column, data one cycle later
        always_ff @(posedge SYS_CLK) begin
            if (rd_req_i.en) begin
                rd_q <= mem[rd_req_i.addr];
            end
        end

        assign rd_col_o[b] = rd_q;
    end

endmodule

//--- rtl/line_writer.sv
/*
 * Line writer.
 * Takes raster-order pixels, steers each row into the next line bank
 * and holds off the source once three rows are buffered.
 */

`include "lbuf_defs.svh"

module line_writer
    import lbuf_pkg::*;
(
    input  logic                SYS_CLK,
    input  logic                SYS_NRST,
    input  logic                sop_i,
    input  logic [`LB_DIMW-1:0] pic_w_i,
    input  logic [`LB_DIMW-1:0] pic_h_i,
    input  pixel_t              pix_i,
    input  logic                pix_vld_i,
    input  logic                row_retire_i,
    output logic                wready_o,
    output wr_req_t             wr_req_o,
    output pic_cfg_t            cfg_o,
    output logic [1:0]          fill_cnt_o,
    output logic [1:0]          row_base_o
);

    pic_cfg_t            cfg_q;
    logic [`LB_AW-1:0]   col_q;     // column of the next pixel
    logic [`LB_DIMW-1:0] row_q;     // rows fully written
    logic [1:0]          wbank_q;
    logic [1:0]          fill_q;
    logic [1:0]          base_q;
    logic [`LB_AW-1:0]   last_col;
    logic                accept;
    logic                row_end;

    function automatic logic [1:0] next_bank(input logic [1:0] bank);
        return (bank == 2'(`LB_BANKS - 1)) ? 2'd0 : bank + 2'd1;
    endfunction

    // ========================================================================
    // flow control

    // after reset h is 0 and row_q is 0, so wready stays low until sop
    assign wready_o = (fill_q != 2'(`LB_BANKS)) && (row_q != cfg_q.h);
    assign accept   = pix_vld_i && wready_o;
    assign last_col = `LB_AW'(cfg_q.w - 1'b1);
    assign row_end  = accept && (col_q == last_col);

    always_comb begin
        wr_req_o.en   = accept;     // lands on this edge
        wr_req_o.bank = wbank_q;
        wr_req_o.addr = col_q;
        wr_req_o.data = pix_i;
    end

    // ========================================================================
    // counters

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            cfg_q   <= '0;
            col_q   <= '0;
            row_q   <= '0;
            wbank_q <= '0;
        end else if (sop_i) begin
            cfg_q.w <= pic_w_i;
            cfg_q.h <= pic_h_i;
            col_q   <= '0;
            row_q   <= '0;
            wbank_q <= '0;
        end else if (accept) begin
            if (row_end) begin
                col_q   <= '0;
                row_q   <= row_q + 1'b1;
                wbank_q <= next_bank(wbank_q);
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // rows held in the banks, and the bank of the reader's top row
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            fill_q <= '0;
            base_q <= '0;
        end else if (sop_i) begin
            fill_q <= '0;
            base_q <= '0;
        end else begin
            case ({row_end, row_retire_i})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;  // both or neither
            endcase
            if (row_retire_i) begin
                base_q <= next_bank(base_q);
            end
        end
    end

    assign cfg_o      = cfg_q;
    assign fill_cnt_o = fill_q;
    assign row_base_o = base_q;

endmodule

//--- rtl/lbuf_pkg.sv
/*
 * Line buffer types.
 * Bank write and read requests, the returned column, the 3x3 window
 * and the reader FSM states.
 */

`include "lbuf_defs.svh"

package lbuf_pkg;

    typedef logic [`LB_DW-1:0] pixel_t;

    // latched at picture start
    typedef struct packed {
        logic [`LB_DIMW-1:0] w;     // pixels per row
        logic [`LB_DIMW-1:0] h;     // rows per picture
    } pic_cfg_t;

    // one pixel into one bank
    typedef struct packed {
        logic               en;
        logic [1:0]         bank;   // row mod 3
        logic [`LB_AW-1:0]  addr;   // column
        pixel_t             data;
    } wr_req_t;

    // same column from all banks
    typedef struct packed {
        logic               en;
        logic [`LB_AW-1:0]  addr;
    } rd_req_t;

    // element b comes from bank b
    typedef pixel_t [`LB_BANKS-1:0] bank_col_t;

    // word 0 is top-left, row-major
    typedef pixel_t [`LB_WIN*`LB_WIN-1:0] window_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_ROWS,
        RD_SCAN,
        RD_DONE
    } rd_state_e;

endpackage

//--- rtl/lbuf_defs.svh
/*
 * Line buffer widths and depths.
 * Shared by the 3x3 window generator RTL and its testbench.
 */

`ifndef LBUF_DEFS_SVH
`define LBUF_DEFS_SVH

// pixel word width
`define LB_DW       32

// column address width, so pictures are at most 255 wide
`define LB_AW       8

// width of the picture width and height fields
`define LB_DIMW     8

// number of line banks, one picture row each
`define LB_BANKS    3

// window edge; a window holds LB_WIN * LB_WIN words
`define LB_WIN      3

`endif
